/* include/blas_defs.svh */
// Sizes are tied to the 32-bit instruction word and 4-bit issue numbers and cannot grow alone
`ifndef BLAS_DEFS_SVH
`define BLAS_DEFS_SVH

//////////////////////////////////////////////////
// Lane array
//////////////////////////////////////////////////
`define NUM_LANES		4		// Lane field of the instruction is 2 bits
`define LMEM_WORDS		16		// Word addresses are 4 bits

//////////////////////////////////////////////////
// Queues and credits
//////////////////////////////////////////////////
`define IN_DEPTH		4		// Also the host's initial input credit
`define LANE_DEPTH		2
`define ROB_DEPTH		8		// Power of two below 16
`define OUT_CREDITS		4

// Multiply-accumulate latency in cycles, at least 2
`define MAD_CYCLES		3

`endif

/* src/blas_pkg.sv */
// Instruction word layout is fixed at 32 bits and opcode 2'd3 is not defined
package blas_pkg;

	typedef enum logic [1:0] {
		SET		= 2'd0,
		MAD		= 2'd1,
		READ	= 2'd2
	} opcode_t;

	typedef logic [3:0]		issue_no_t;		// Wraps at 16
	typedef logic [15:0]	data_t;

	// Host instruction word
	typedef struct packed {
		opcode_t		op;
		logic [1:0]		lane;
		logic [3:0]		dst;
		logic [3:0]		src_a;
		logic [3:0]		src_b;
		data_t			imm;
	} instr_t;

	// Word held in a lane queue
	typedef struct packed {
		opcode_t		op;
		logic [3:0]		dst;
		logic [3:0]		src_a;
		logic [3:0]		src_b;
		data_t			imm;
		issue_no_t		issue_no;
	} lane_op_t;

	// Lane and host result record
	typedef struct packed {
		issue_no_t		issue_no;
		data_t			data;
	} result_t;

endpackage

/* src/credit_fifo.sv */
// Every push must be covered by a credit held upstream since the queue has no overflow check
`timescale 1ns/10ps

module credit_fifo
	import blas_pkg::*;
#(
	parameter type	payload_t	= instr_t,
	parameter int	DEPTH		= 4
)(
	input	logic			clock,
	input	logic			reset,
	input	logic			push,
	input	payload_t		push_data,
	input	logic			pop,
	output	payload_t		head,
	output	logic			not_empty,
	output	logic			credit
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t			mem [DEPTH];
	logic [PW-1:0]		wr_ptr;
	logic [PW-1:0]		rd_ptr;
	logic [CW-1:0]		count;
	logic				do_pop;

	assign not_empty	= (count != '0);
	assign head			= mem[rd_ptr];
	assign do_pop		= pop & not_empty;
	assign credit		= do_pop;			// One credit back per popped entry

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end
		else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CW'(push) - CW'(do_pop);
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

endmodule

/* src/instr_decode.sv */
// Lane field selects the lane directly so NUM_LANES must stay at 4 and the window below 16
`timescale 1ns/10ps

`include "blas_defs.svh"

module instr_decode
	import blas_pkg::*;
(
	input	logic						clock,
	input	logic						reset,
	input	instr_t						instr_head,
	input	logic						instr_ready,
	output	logic						instr_pop,
	output	logic [`NUM_LANES-1:0]		disp_valid,
	output	lane_op_t					disp_op,
	input	logic [`NUM_LANES-1:0]		lane_credit,
	input	logic						commit_pulse
);

	localparam int LCW = $clog2(`LANE_DEPTH + 1);
	localparam int WCW = $clog2(`ROB_DEPTH + 1);

	logic [LCW-1:0]		lane_cnt [`NUM_LANES];
	logic [WCW-1:0]		window_cnt;
	issue_no_t			issue_cnt;
	logic				lane_free;
	logic				window_free;

	//////////////////////////////////////////////////
	// Issue condition
	//////////////////////////////////////////////////
	assign lane_free	= (lane_cnt[instr_head.lane] != '0);
	assign window_free	= (window_cnt < WCW'(`ROB_DEPTH));
	assign instr_pop	= instr_ready & lane_free & window_free;

	always_comb begin
		disp_valid = '0;
		disp_valid[instr_head.lane] = instr_pop;
	end

	// Lane field dropped, issue number appended
	always_comb begin
		disp_op.op			= instr_head.op;
		disp_op.dst			= instr_head.dst;
		disp_op.src_a		= instr_head.src_a;
		disp_op.src_b		= instr_head.src_b;
		disp_op.imm			= instr_head.imm;
		disp_op.issue_no	= issue_cnt;
	end

	//////////////////////////////////////////////////
	// Counters
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			issue_cnt	<= '0;
			window_cnt	<= '0;
			for (int i = 0; i < `NUM_LANES; i++) begin
				lane_cnt[i] <= LCW'(`LANE_DEPTH);
			end
		end
		else begin
			if (instr_pop) begin
				issue_cnt <= issue_cnt + 1'b1;
			end
			// Outstanding issue numbers
			window_cnt <= window_cnt + WCW'(instr_pop) - WCW'(commit_pulse);
			for (int i = 0; i < `NUM_LANES; i++) begin
				lane_cnt[i] <= lane_cnt[i] + LCW'(lane_credit[i]) - LCW'(disp_valid[i]);
			end
		end
	end

endmodule

/* src/lane_execute.sv */
// One operation at a time per lane, a MAD blocks the lane for MAD_CYCLES which must be 2 or more
`timescale 1ns/10ps

`include "blas_defs.svh"

module lane_execute
	import blas_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			op_ready,
	input	lane_op_t		op_head,
	output	logic			op_pop,
	output	logic			done,
	output	result_t		result
);

	localparam int BW = $clog2(`MAD_CYCLES + 1);

	data_t				lmem [`LMEM_WORDS];
	logic [BW-1:0]		busy_cnt;
	logic				mad_fire;

	// MAD operands held while the lane is busy
	logic [3:0]			mad_dst;
	issue_no_t			mad_issue;
	data_t				mad_acc;
	data_t				mad_a;
	data_t				mad_b;
	logic [31:0]		mad_prod;
	data_t				mad_sum;

	assign op_pop	= op_ready & (busy_cnt == '0);		// Idle lane only
	assign mad_fire	= (busy_cnt == BW'(1));

	assign mad_prod	= mad_a * mad_b;
	assign mad_sum	= mad_acc + mad_prod[15:0];		// Low 16 bits kept

	//////////////////////////////////////////////////
	// Control and local memory
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			busy_cnt	<= '0;
			done		<= 1'b0;
			for (int w = 0; w < `LMEM_WORDS; w++) begin
				lmem[w] <= '0;
			end
		end
		else begin
			done <= 1'b0;
			if (busy_cnt != '0) begin
				busy_cnt <= busy_cnt - 1'b1;
			end
			if (mad_fire) begin
				lmem[mad_dst]	<= mad_sum;
				done			<= 1'b1;
			end
			if (op_pop) begin
				case (op_head.op)
					SET: begin
						lmem[op_head.dst]	<= op_head.imm;
						done				<= 1'b1;
					end
					MAD: begin
						busy_cnt <= BW'(`MAD_CYCLES - 1);
					end
					default: begin
						done <= 1'b1;					// READ
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Result and MAD operand registers
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (mad_fire) begin
			result.issue_no	<= mad_issue;
			result.data		<= mad_sum;
		end
		else if (op_pop) begin
			result.issue_no	<= op_head.issue_no;
			result.data		<= (op_head.op == SET) ? op_head.imm : lmem[op_head.src_a];
		end

		if (op_pop && (op_head.op == MAD)) begin
			mad_dst		<= op_head.dst;
			mad_issue	<= op_head.issue_no;
			mad_acc		<= lmem[op_head.dst];
			mad_a		<= lmem[op_head.src_a];
			mad_b		<= lmem[op_head.src_b];
		end
	end

endmodule

/* src/commit_agg.sv */
// Lane results are taken without back-pressure since the decode window keeps a slot free for each
`timescale 1ns/10ps

`include "blas_defs.svh"

module commit_agg
	import blas_pkg::*;
(
	input	logic						clock,
	input	logic						reset,
	input	logic [`NUM_LANES-1:0]		lane_done,
	input	result_t					lane_result [`NUM_LANES],
	input	logic						out_credit,
	output	logic						out_valid,
	output	issue_no_t					out_issue_no,
	output	data_t						out_data,
	output	logic						commit_pulse
);

	localparam int IW = $clog2(`ROB_DEPTH);
	localparam int CW = $clog2(`OUT_CREDITS + 1);

	data_t						rob_data [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0]		rob_valid;
	issue_no_t					head_no;
	logic [IW-1:0]				head_idx;
	logic [CW-1:0]				out_cnt;

	assign head_idx		= head_no[IW-1:0];

	//////////////////////////////////////////////////
	// Host output
	//////////////////////////////////////////////////
	assign out_valid	= rob_valid[head_idx] & (out_cnt != '0);
	assign out_issue_no	= head_no;
	assign out_data		= rob_data[head_idx];
	assign commit_pulse	= out_valid;			// Frees one window entry in decode

	//////////////////////////////////////////////////
	// Slot state, head and credits
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			rob_valid	<= '0;
			head_no		<= '0;
			out_cnt		<= CW'(`OUT_CREDITS);
		end
		else begin
			if (out_valid) begin
				rob_valid[head_idx]	<= 1'b0;
				head_no				<= head_no + 1'b1;
			end

			// Arrivals never hit the slot being released
			for (int i = 0; i < `NUM_LANES; i++) begin
				if (lane_done[i]) begin
					rob_valid[lane_result[i].issue_no[IW-1:0]] <= 1'b1;
				end
			end

			out_cnt <= out_cnt + CW'(out_credit) - CW'(out_valid);
		end
	end

	// Result data by slot
	always_ff @(posedge clock) begin
		for (int i = 0; i < `NUM_LANES; i++) begin
			if (lane_done[i]) begin
				rob_data[lane_result[i].issue_no[IW-1:0]] <= lane_result[i].data;
			end
		end
	end

endmodule

/* src/blas_engine.sv */
// Host must hold a credit for every in_valid and return out_credit once per result it takes
`timescale 1ns/10ps

`include "blas_defs.svh"

module blas_engine
	import blas_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			in_valid,
	input	instr_t			in_instr,
	output	logic			in_credit,
	output	logic			out_valid,
	output	issue_no_t		out_issue_no,
	output	data_t			out_data,
	input	logic			out_credit
);

	// Input queue to decode
	instr_t						in_head;
	logic						in_ready;
	logic						in_pop;

	// Decode to lane queues
	logic [`NUM_LANES-1:0]		disp_valid;
	lane_op_t					disp_op;
	logic [`NUM_LANES-1:0]		lq_credit;

	// Lane queues to lanes
	lane_op_t					lq_head [`NUM_LANES];
	logic [`NUM_LANES-1:0]		lq_ready;
	logic [`NUM_LANES-1:0]		lq_pop;

	// Lanes to commit
	logic [`NUM_LANES-1:0]		lane_done;
	result_t					lane_result [`NUM_LANES];
	logic						commit_pulse;

	credit_fifo #(
		.payload_t(		instr_t				),
		.DEPTH(			`IN_DEPTH			)
	) in_queue_i (
		.clock(			clock				),
		.reset(			reset				),
		.push(			in_valid			),
		.push_data(		in_instr			),
		.pop(			in_pop				),
		.head(			in_head				),
		.not_empty(		in_ready			),
		.credit(		in_credit			)
	);

	instr_decode instr_decode_i (
		.clock(			clock				),
		.reset(			reset				),
		.instr_head(	in_head				),
		.instr_ready(	in_ready			),
		.instr_pop(		in_pop				),
		.disp_valid(	disp_valid			),
		.disp_op(		disp_op				),
		.lane_credit(	lq_credit			),
		.commit_pulse(	commit_pulse		)
	);

	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
		credit_fifo #(
			.payload_t(		lane_op_t			),
			.DEPTH(			`LANE_DEPTH			)
		) lane_queue_i (
			.clock(			clock				),
			.reset(			reset				),
			.push(			disp_valid[i]		),
			.push_data(		disp_op				),
			.pop(			lq_pop[i]			),
			.head(			lq_head[i]			),
			.not_empty(		lq_ready[i]			),
			.credit(		lq_credit[i]		)
		);

		lane_execute lane_execute_i (
			.clock(			clock				),
			.reset(			reset				),
			.op_ready(		lq_ready[i]			),
			.op_head(		lq_head[i]			),
			.op_pop(		lq_pop[i]			),
			.done(			lane_done[i]		),
			.result(		lane_result[i]		)
		);
	end

	commit_agg commit_agg_i (
		.clock(			clock				),
		.reset(			reset				),
		.lane_done(		lane_done			),
		.lane_result(	lane_result			),
		.out_credit(	out_credit			),
		.out_valid(		out_valid			),
		.out_issue_no(	out_issue_no		),
		.out_data(		out_data			),
		.commit_pulse(	commit_pulse		)
	);

endmodule

/* testbench/blas_engine_assert.sv */
// Checks only the host side of blas_engine and counts its failures in fail_count for the testbench
`timescale 1ns/10ps

module blas_engine_assert
	import blas_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			in_valid,
	input	logic			in_credit,
	input	logic			out_valid,
	input	issue_no_t		out_issue_no
);

	int				fail_count = 0;
	issue_no_t		next_no;			// Issue number expected on the next out_valid
	int unsigned	accepted;
	int unsigned	credited;

	always_ff @(posedge clock) begin
		if (reset) begin
			next_no		<= '0;
			accepted	<= 0;
			credited	<= 0;
		end
		else begin
			if (out_valid) begin
				next_no <= next_no + 1'b1;
			end
			accepted	<= accepted + in_valid;
			credited	<= credited + in_credit;
		end
	end

	quiet_in_reset: assert property (@(posedge clock)
		(reset && $past(reset)) |-> (!out_valid && !in_credit))
	else begin
		fail_count++;
		$error("out_valid or in_credit high during reset");
	end

	issue_in_order: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> (out_issue_no == next_no))
	else begin
		fail_count++;
		$error("out_valid issue number %0d, expected %0d", out_issue_no, next_no);
	end

	// A credit needs an entry pushed in an earlier cycle
	credit_bound: assert property (@(posedge clock) disable iff (reset)
		in_credit |-> (credited < accepted))
	else begin
		fail_count++;
		$error("in_credit pulsed without an accepted instruction");
	end

endmodule

bind blas_engine blas_engine_assert blas_engine_assert_i (
	.clock(			clock			),
	.reset(			reset			),
	.in_valid(		in_valid		),
	.in_credit(		in_credit		),
	.out_valid(		out_valid		),
	.out_issue_no(	out_issue_no	)
);

/* testbench/tb_blas_engine.sv */
// Fixed seed run, every wait gives up after WAIT_LIMIT cycles and reference memories start at zero
`timescale 1ns/10ps

`include "blas_defs.svh"

module tb_blas_engine
	import blas_pkg::*;
();

	localparam int WAIT_LIMIT = 500;

	logic			clock = 1'b0;
	logic			reset;
	logic			in_valid;
	instr_t			in_instr;
	logic			in_credit;
	logic			out_valid;
	issue_no_t		out_issue_no;
	data_t			out_data;
	logic			out_credit = 1'b0;

	int				sent_count = 0;
	int				credits_returned = 0;
	int				results_seen = 0;
	int				credits_given = 0;
	int				mismatch_count = 0;
	int				other_count = 0;
	int				delay_left = 0;
	int				credit_mark;
	int				base_results;
	int				credit_delays [$];		// Output credit delays, filled by the main process
	logic			hold_credits = 1'b0;
	string			test_name = "reset";

	// Reference model
	data_t			ref_mem [`NUM_LANES][`LMEM_WORDS];
	issue_no_t		ref_issue = '0;
	result_t		exp_q [$];
	result_t		exp_head;

	blas_engine blas_engine_i (
		.clock(			clock			),
		.reset(			reset			),
		.in_valid(		in_valid		),
		.in_instr(		in_instr		),
		.in_credit(		in_credit		),
		.out_valid(		out_valid		),
		.out_issue_no(	out_issue_no	),
		.out_data(		out_data		),
		.out_credit(	out_credit		)
	);

	always #10 clock = ~clock;

	//////////////////////////////////////////////////
	// Host side monitor and output credit return
	//////////////////////////////////////////////////
	always @(posedge clock) begin
		if (!reset) begin
			if (in_credit) begin
				credits_returned++;
			end
			if (out_valid) begin
				results_seen++;				// Every result the host takes
			end
			if (out_valid && exp_q.size() == 0) begin
				other_count++;
				$display("Result %0d arrived with nothing outstanding in %s", out_issue_no, test_name);
			end
			else if (out_valid) begin
				exp_head = exp_q.pop_front();
				check_result: assert (out_issue_no == exp_head.issue_no && out_data == exp_head.data)
				else begin
					mismatch_count++;
					$display("Mismatch %s: expected issue %0d data %h, actual issue %0d data %h",
						test_name, exp_head.issue_no, exp_head.data, out_issue_no, out_data);
				end
			end
		end
	end

	always @(negedge clock) begin
		out_credit = 1'b0;
		if (!reset && !hold_credits && results_seen > credits_given) begin
			if (delay_left == 0) begin
				out_credit = 1'b1;
				credits_given++;
				delay_left = (credit_delays.size() > 0) ? credit_delays.pop_front() : 0;
			end
			else begin
				delay_left--;
			end
		end
	end

	function automatic int host_credits();
		return `IN_DEPTH + credits_returned - sent_count;
	endfunction

	task automatic report_counts();
		$display("Errors: %0d mismatch, %0d other, %0d assertion", mismatch_count, other_count,
			blas_engine_i.blas_engine_assert_i.fail_count);
	endtask

	task automatic abort_on_timeout(input string what);
		other_count++;
		$display("Timed out in %s waiting for %s", test_name, what);
		report_counts();
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		count_check: assert (expected == actual)
		else begin
			mismatch_count++;
			$display("Mismatch %s (%s): expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	task automatic send_instr(input opcode_t op, input int lane, input int dst,
			input int src_a, input int src_b, input data_t imm);
		int				waited;
		logic [31:0]	prod;
		data_t			exp_data;
		waited = 0;
		while (host_credits() == 0 && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (waited >= WAIT_LIMIT) begin
			abort_on_timeout("an input credit");
		end
		in_instr = '{op, 2'(lane), 4'(dst), 4'(src_a), 4'(src_b), imm};
		in_valid = 1'b1;
		sent_count++;
		case (op)
			SET: begin
				ref_mem[lane][dst] = imm;
				exp_data = imm;
			end
			MAD: begin
				prod = ref_mem[lane][src_a] * ref_mem[lane][src_b];
				ref_mem[lane][dst] = ref_mem[lane][dst] + prod[15:0];	// Low half of product
				exp_data = ref_mem[lane][dst];
			end
			default: exp_data = ref_mem[lane][src_a];
		endcase
		exp_q.push_back('{ref_issue, exp_data});
		ref_issue++;
		@(negedge clock);
		in_valid = 1'b0;
	endtask

	task automatic send_random();
		opcode_t	op;
		int			lane;
		int			dst;
		int			src_a;
		int			src_b;
		op		= opcode_t'($urandom_range(0, 2));
		lane	= $urandom_range(0, `NUM_LANES - 1);
		dst		= $urandom_range(0, 15);
		src_a	= $urandom_range(0, 15);
		src_b	= $urandom_range(0, 15);
		send_instr(op, lane, dst, src_a, src_b, data_t'($urandom_range(0, 65535)));
	endtask

	// All results back and all output credits returned
	task automatic wait_idle();
		int waited;
		waited = 0;
		while ((exp_q.size() != 0 || credits_given != results_seen) && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (waited >= WAIT_LIMIT) begin
			abort_on_timeout("outstanding results");
		end
		repeat (2) @(negedge clock);
	endtask

	initial begin
		void'($urandom(32'h9c0ecc99));
		reset		= 1'b1;
		in_valid	= 1'b0;
		in_instr	= '0;
		for (int l = 0; l < `NUM_LANES; l++) begin
			for (int w = 0; w < `LMEM_WORDS; w++) begin
				ref_mem[l][w] = '0;
			end
		end
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		repeat (10) @(negedge clock);
		check_value("results after reset", 0, results_seen);
		for (int l = 0; l < `NUM_LANES; l++) begin
			send_instr(SET, l, 0, 0, 0, data_t'($urandom_range(0, 65535)));
		end
		wait_idle();
		check_value("input credits returned", `IN_DEPTH, credits_returned);

		test_name = "set_read";
		for (int l = 0; l < `NUM_LANES; l++) begin
			send_instr(SET, l, l + 2, 0, 0, data_t'($urandom_range(0, 65535)));
			send_instr(READ, l, 0, l + 2, 0, '0);
			send_instr(READ, (l + 1) % `NUM_LANES, 0, l + 2, 0, '0);	// Same word, other lane
		end
		wait_idle();

		test_name = "mad";
		send_instr(SET, 2, 6, 0, 0, data_t'($urandom_range(0, 65535)));
		send_instr(SET, 2, 7, 0, 0, data_t'($urandom_range(0, 65535)));
		send_instr(SET, 2, 8, 0, 0, data_t'($urandom_range(0, 65535)));
		send_instr(MAD, 2, 8, 6, 7, '0);
		send_instr(READ, 2, 0, 8, 0, '0);
		wait_idle();

		// Short READs overtake the MAD inside the engine
		test_name = "mad_order";
		send_instr(SET, 0, 2, 0, 0, data_t'($urandom_range(0, 65535)));
		send_instr(SET, 0, 3, 0, 0, data_t'($urandom_range(0, 65535)));
		wait_idle();
		send_instr(MAD, 0, 1, 2, 3, '0);
		send_instr(READ, 1, 0, 2, 0, '0);
		send_instr(READ, 2, 0, 8, 0, '0);
		send_instr(READ, 3, 0, 3, 0, '0);
		wait_idle();

		test_name = "credit_hold";
		hold_credits = 1'b1;
		base_results = results_seen;
		for (int c = 0; c < 60; c++) begin
			if (host_credits() > 0) begin
				send_random();
			end
			else begin
				@(negedge clock);
			end
			if (c == 40) begin
				credit_mark = credits_returned;
			end
		end
		check_value("results while held", `OUT_CREDITS, results_seen - base_results);
		check_value("input credits while stalled", credit_mark, credits_returned);
		hold_credits = 1'b0;
		wait_idle();

		test_name = "random_burst";
		for (int i = 0; i < 60; i++) begin
			credit_delays.push_back($urandom_range(0, 6));
		end
		for (int i = 0; i < 60; i++) begin
			send_random();
		end
		wait_idle();
		check_value("results returned", sent_count, results_seen);

		report_counts();
		if (mismatch_count + other_count + blas_engine_i.blas_engine_assert_i.fail_count == 0) begin
			$display("TEST OK");
		end
		else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+include
src/blas_pkg.sv
src/credit_fifo.sv
src/instr_decode.sv
src/lane_execute.sv
src/commit_agg.sv
src/blas_engine.sv
testbench/blas_engine_assert.sv
testbench/tb_blas_engine.sv
